//--- instCache.f
+incdir+hdl
hdl/icachePkg.sv
hdl/wayRam.sv
hdl/tagLookup.sv
hdl/plruTracker.sv
hdl/refillControl.sv
hdl/fetchPairSelect.sv
hdl/instCache.sv
verif/instCacheChecker.sv
verif/instCacheTb.sv

//--- Bender.yml
package:
  name: instCache

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/icachePkg.sv
      - hdl/wayRam.sv
      - hdl/tagLookup.sv
      - hdl/plruTracker.sv
      - hdl/refillControl.sv
      - hdl/fetchPairSelect.sv
      - hdl/instCache.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verif/instCacheChecker.sv
      - verif/instCacheTb.sv

//--- verif/instCacheTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_macros.svh"

module instCacheTb
    import icachePkg::*;
();

    localparam int          NumRows           = 20;
    localparam int          OutcomeWaitCycles = 8;
    localparam int          StallWaitCycles   = 16;
    localparam logic [31:0] Seed              = 32'hf03e;
    localparam logic [31:0] PatternKey        = 32'h5a5a0000;
    localparam logic [1:0]  ExpHit            = 2'd1;
    localparam logic [1:0]  ExpMiss           = 2'd2;
    localparam logic [1:0]  ExpDrop           = 2'd3;

    logic        clk;
    logic        rst;
    cacheAddrT   fetchPc;
    logic        fetchValid;
    logic        flush;
    logic        stallReq;
    logic        memReqValid;
    cacheAddrT   memReqAddr;
    logic        memRespValid;
    cacheLineT   memRespLine;
    logic        inst0Valid;
    instWordT    inst0;
    cacheAddrT   inst0Pc;
    logic        inst1Valid;
    instWordT    inst1;
    cacheAddrT   inst1Pc;
    logic        rowDone;
    logic [7:0]  rowId;
    logic [1:0]  rowExpect;
    int          errorCount;
    int          testsRun;
    int          testsFailed;
    logic        timedOut;
    // expected outcome, flush after the request, fetch PC
    logic [34:0] stimTable [NumRows];

    instCache i_dut (
        .clk          (clk),
        .rst          (rst),
        .fetchPc      (fetchPc),
        .fetchValid   (fetchValid),
        .flush        (flush),
        .stallReq     (stallReq),
        .memReqValid  (memReqValid),
        .memReqAddr   (memReqAddr),
        .memRespValid (memRespValid),
        .memRespLine  (memRespLine),
        .inst0Valid   (inst0Valid),
        .inst0        (inst0),
        .inst0Pc      (inst0Pc),
        .inst1Valid   (inst1Valid),
        .inst1        (inst1),
        .inst1Pc      (inst1Pc)
    );

    instCacheChecker scoreboard (
        .clk          (clk),
        .rst          (rst),
        .fetchPc      (fetchPc),
        .fetchValid   (fetchValid),
        .flush        (flush),
        .stallReq     (stallReq),
        .memReqValid  (memReqValid),
        .memReqAddr   (memReqAddr),
        .memRespValid (memRespValid),
        .memRespLine  (memRespLine),
        .inst0Valid   (inst0Valid),
        .inst0        (inst0),
        .inst0Pc      (inst0Pc),
        .inst1Valid   (inst1Valid),
        .inst1        (inst1),
        .inst1Pc      (inst1Pc),
        .rowDone      (rowDone),
        .rowId        (rowId),
        .rowExpect    (rowExpect),
        .errorCount   (errorCount),
        .testsRun     (testsRun),
        .testsFailed  (testsFailed)
    );

    always #50 clk = ~clk;

    task automatic loadTable();
        stimTable[0]  = {ExpMiss, 1'b0, 32'h0000_1000};
        stimTable[1]  = {ExpHit,  1'b0, 32'h0000_1004};
        stimTable[2]  = {ExpHit,  1'b0, 32'h0000_1008};
        stimTable[3]  = {ExpHit,  1'b0, 32'h0000_100c};
        stimTable[4]  = {ExpMiss, 1'b0, 32'h0000_201c};
        stimTable[5]  = {ExpHit,  1'b0, 32'h0000_2010};
        // five tags in set 5 with hits in between
        stimTable[6]  = {ExpMiss, 1'b0, 32'h0000_4050};
        stimTable[7]  = {ExpMiss, 1'b0, 32'h0000_4454};
        stimTable[8]  = {ExpMiss, 1'b0, 32'h0000_4858};
        stimTable[9]  = {ExpHit,  1'b0, 32'h0000_405c};
        stimTable[10] = {ExpMiss, 1'b0, 32'h0000_4c50};
        stimTable[11] = {ExpHit,  1'b0, 32'h0000_4450};
        stimTable[12] = {ExpMiss, 1'b0, 32'h0000_5050};
        stimTable[13] = {ExpMiss, 1'b0, 32'h0000_4850};
        stimTable[14] = {ExpHit,  1'b0, 32'h0000_4050};
        stimTable[15] = {ExpMiss, 1'b0, 32'h0000_4c54};
        stimTable[16] = {ExpHit,  1'b0, 32'h0000_5058};
        // flushed refill must leave the line out of the cache
        stimTable[17] = {ExpDrop, 1'b1, 32'h0000_8030};
        stimTable[18] = {ExpMiss, 1'b0, 32'h0000_8038};
        stimTable[19] = {ExpHit,  1'b0, 32'h0000_8034};
    endtask

    function automatic cacheLineT patternLine(cacheAddrT lineAddr);
        cacheLineT line;
        for (int i = 0; i < 4; i++) begin
            line[i*`ICACHE_INST_BITS +: `ICACHE_INST_BITS] =
                (lineAddr + cacheAddrT'(4 * i)) ^ PatternKey;
        end
        return line;
    endfunction

    task automatic waitOutcome(output logic sawReq, output cacheAddrT reqAddr);
        int   cycles;
        logic seen;
        sawReq  = 1'b0;
        reqAddr = '0;
        seen    = 1'b0;
        cycles  = 0;
        while (!seen && cycles < OutcomeWaitCycles) begin
            @(posedge clk);
            cycles++;
            if (memReqValid || inst0Valid || inst1Valid) begin
                seen    = 1'b1;
                sawReq  = memReqValid;
                reqAddr = memReqAddr;
            end
        end
        if (!seen) begin
            $display("timeout: no request and no delivery after fetch of %h", fetchPc);
            timedOut = 1'b1;
        end
    endtask

    task automatic waitStallLow();
        int   cycles;
        logic low;
        low    = 1'b0;
        cycles = 0;
        while (!low && cycles < StallWaitCycles) begin
            @(posedge clk);
            cycles++;
            low = !stallReq;
        end
        if (!low) begin
            $display("timeout: stallReq stayed high after the memory response");
            timedOut = 1'b1;
        end
    endtask

    // memory answers a miss after a random number of wait cycles
    task automatic serveMiss(input cacheAddrT lineAddr, input logic withFlush);
        int latency;
        latency = 1 + int'($urandom % 6);
        @(negedge clk);
        flush = withFlush;
        for (int i = 0; i < latency; i++) begin
            @(negedge clk);
            flush = 1'b0;
        end
        memRespValid = 1'b1;
        memRespLine  = patternLine(lineAddr);
        @(negedge clk);
        memRespValid = 1'b0;
    endtask

    task automatic runRow(input int idx);
        logic      sawReq;
        cacheAddrT reqAddr;
        @(negedge clk);
        fetchPc    = stimTable[idx][31:0];
        fetchValid = 1'b1;
        @(negedge clk);
        fetchValid = 1'b0;
        waitOutcome(sawReq, reqAddr);
        if (!timedOut && sawReq) begin
            serveMiss(reqAddr, stimTable[idx][32]);
            waitStallLow();
        end
        if (!timedOut) begin
            @(negedge clk);
            rowDone   = 1'b1;
            rowId     = idx[7:0];
            rowExpect = stimTable[idx][34:33];
            @(negedge clk);
            rowDone = 1'b0;
        end
    endtask

    initial begin
        int row;
        clk          = 1'b0;
        rst          = 1'b1;
        fetchPc      = '0;
        fetchValid   = 1'b0;
        flush        = 1'b0;
        memRespValid = 1'b0;
        memRespLine  = '0;
        rowDone      = 1'b0;
        rowId        = '0;
        rowExpect    = '0;
        timedOut     = 1'b0;
        void'($urandom(Seed));
        loadTable();
        repeat (3) @(negedge clk);
        rst = 1'b0;
        for (row = 0; row < NumRows && !timedOut; row++) begin
            runRow(row);
        end
        @(negedge clk);
        $display("tests run %0d, tests failed %0d, wrong values %0d", testsRun, testsFailed,
                 errorCount);
        if (!timedOut && testsFailed == 0 && errorCount == 0 && testsRun == NumRows) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/instCacheChecker.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_macros.svh"

module instCacheChecker
    import icachePkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  cacheAddrT  fetchPc,
    input  logic       fetchValid,
    input  logic       flush,
    input  logic       stallReq,
    input  logic       memReqValid,
    input  cacheAddrT  memReqAddr,
    input  logic       memRespValid,
    input  cacheLineT  memRespLine,
    input  logic       inst0Valid,
    input  instWordT   inst0,
    input  cacheAddrT  inst0Pc,
    input  logic       inst1Valid,
    input  instWordT   inst1,
    input  cacheAddrT  inst1Pc,
    input  logic       rowDone,
    input  logic [7:0] rowId,
    input  logic [1:0] rowExpect,
    output int         errorCount,
    output int         testsRun,
    output int         testsFailed
);

    localparam logic [1:0] OutNone = 2'd0;
    localparam logic [1:0] OutHit  = 2'd1;
    localparam logic [1:0] OutMiss = 2'd2;
    localparam logic [1:0] OutDrop = 2'd3;

    cacheTagT   modelTag   [`ICACHE_WAYS][`ICACHE_SETS];
    cacheLineT  modelLine  [`ICACHE_WAYS][`ICACHE_SETS];
    logic       modelValid [`ICACHE_WAYS][`ICACHE_SETS];
    plruBitsT   modelPlru  [`ICACHE_SETS];
    logic       capValid;
    cacheAddrT  capPc;
    logic       waitResp;
    logic       dropResp;
    logic [1:0] seenOutcome;
    int         rowErrors;

    initial begin
        errorCount  = 0;
        testsRun    = 0;
        testsFailed = 0;
        rowErrors   = 0;
        seenOutcome = OutNone;
        capValid    = 1'b0;
        waitResp    = 1'b0;
        dropResp    = 1'b0;
    end

    // root bit set means the upper pair was used last
    function automatic int victimOf(plruBitsT bits);
        if (bits[0]) begin
            return bits[1] ? 0 : 1;
        end
        return bits[2] ? 2 : 3;
    endfunction

    function automatic plruBitsT afterUse(plruBitsT bits, int way);
        plruBitsT result;
        result = bits;
        if (way < 2) begin
            result[0] = 1'b0;
            result[1] = (way == 1);
        end else begin
            result[0] = 1'b1;
            result[2] = (way == 3);
        end
        return result;
    endfunction

    function automatic string outcomeName(logic [1:0] code);
        case (code)
            OutHit:  return "hit";
            OutMiss: return "miss";
            OutDrop: return "dropped";
            default: return "nothing";
        endcase
    endfunction

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s expected %h got %h", name, expected, actual);
            errorCount++;
            rowErrors++;
        end
    endtask

    task automatic checkDelivery(input logic expDeliver, input cacheAddrT pc,
                                 input cacheLineT line);
        cacheAddrT basePc;
        int        word;
        basePc = {pc[31:3], 3'b000};
        word   = pc[3] ? 2 : 0;
        compareValue("inst0Valid", expDeliver && !pc[2], inst0Valid);
        compareValue("inst1Valid", expDeliver, inst1Valid);
        if (expDeliver) begin
            compareValue("inst0", line[word*32 +: 32], inst0);
            compareValue("inst1", line[(word+1)*32 +: 32], inst1);
            compareValue("inst0Pc", basePc, inst0Pc);
            compareValue("inst1Pc", basePc + 32'd4, inst1Pc);
        end
    endtask

    task automatic reportRow();
        string label;
        label = outcomeName(rowExpect);
        testsRun++;
        if (seenOutcome != rowExpect) begin
            $display("test %0d pc %h: expected a %s but the cache gave %s",
                     rowId, fetchPc, label, outcomeName(seenOutcome));
            errorCount++;
            testsFailed++;
        end else if (rowErrors != 0) begin
            $display("test %0d pc %h %s: %0d wrong values", rowId, fetchPc, label, rowErrors);
            testsFailed++;
        end else begin
            $display("test %0d pc %h %s: ok", rowId, fetchPc, label);
        end
        seenOutcome = OutNone;
        rowErrors   = 0;
    endtask

    always @(posedge clk) begin : watchDut
        logic      expReq;
        logic      expStall;
        logic      expDeliver;
        cacheLineT outLine;
        setIndexT  set;
        cacheTagT  tag;
        int        way;

        expReq     = 1'b0;
        expStall   = 1'b0;
        expDeliver = 1'b0;
        outLine    = '0;
        if (rst) begin
            capValid = 1'b0;
            waitResp = 1'b0;
            dropResp = 1'b0;
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                modelPlru[s] = '0;
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    modelValid[w][s] = 1'b0;
                end
            end
        end else begin
            set = capPc[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
            tag = capPc[31 -: `ICACHE_TAG_BITS];
            if (waitResp) begin
                expStall = !memRespValid;
                if (memRespValid) begin
                    waitResp = 1'b0;
                    if (dropResp) begin
                        seenOutcome = OutDrop;
                    end else begin
                        way = victimOf(modelPlru[set]);
                        modelTag[way][set]   = tag;
                        modelLine[way][set]  = memRespLine;
                        modelValid[way][set] = 1'b1;
                        modelPlru[set]       = afterUse(modelPlru[set], way);
                        expDeliver  = !flush;
                        outLine     = memRespLine;
                        seenOutcome = OutMiss;
                    end
                end else if (flush) begin
                    dropResp = 1'b1;
                end
            end else if (capValid) begin
                way = -1;
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    if (modelValid[w][set] && modelTag[w][set] == tag) begin
                        way = w;
                    end
                end
                if (way >= 0) begin
                    modelPlru[set] = afterUse(modelPlru[set], way);
                    expDeliver  = !flush;
                    outLine     = modelLine[way][set];
                    seenOutcome = OutHit;
                end else if (!flush) begin
                    expReq   = 1'b1;
                    expStall = 1'b1;
                    waitResp = 1'b1;
                    dropResp = 1'b0;
                end else begin
                    seenOutcome = OutDrop;
                end
            end
            compareValue("stallReq", expStall, stallReq);
            compareValue("memReqValid", expReq, memReqValid);
            if (expReq) begin
                compareValue("memReqAddr", {capPc[31:4], 4'b0000}, memReqAddr);
            end
            checkDelivery(expDeliver, capPc, outLine);
            // the cache only takes a new fetch while not stalled
            if (!expStall) begin
                capValid = fetchValid && !flush;
                capPc    = fetchPc;
            end
            if (rowDone) begin
                reportRow();
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/instCache.sv
`timescale 1ns/100ps
`default_nettype none

module instCache
    import icachePkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  cacheAddrT fetchPc,
    input  logic      fetchValid,
    input  logic      flush,
    output logic      stallReq,
    output logic      memReqValid,
    output cacheAddrT memReqAddr,
    input  logic      memRespValid,
    input  cacheLineT memRespLine,
    output logic      inst0Valid,
    output instWordT  inst0,
    output cacheAddrT inst0Pc,
    output logic      inst1Valid,
    output instWordT  inst1,
    output cacheAddrT inst1Pc
);

    logic      lookupValid;
    logic      hit;
    wayMaskT   hitWay;
    setIndexT  lookupSet;
    cacheAddrT lookupPc;
    cacheLineT lookupLine;
    wayMaskT   victimWay;
    logic      deliver;
    logic      hitTouch;
    logic      fillEn;

    tagLookup lookup (
        .clk         (clk),
        .rst         (rst),
        .fetchPc     (fetchPc),
        .fetchValid  (fetchValid),
        .flush       (flush),
        .stallReq    (stallReq),
        .fillEn      (fillEn),
        .victimWay   (victimWay),
        .memRespLine (memRespLine),
        .lookupValid (lookupValid),
        .hit         (hit),
        .hitWay      (hitWay),
        .lookupSet   (lookupSet),
        .lookupPc    (lookupPc),
        .memReqAddr  (memReqAddr),
        .lookupLine  (lookupLine)
    );

    plruTracker replacement (
        .clk       (clk),
        .rst       (rst),
        .lookupSet (lookupSet),
        .hitTouch  (hitTouch),
        .hitWay    (hitWay),
        .fillEn    (fillEn),
        .victimWay (victimWay)
    );

    refillControl control (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .lookupValid  (lookupValid),
        .hit          (hit),
        .memRespValid (memRespValid),
        .stallReq     (stallReq),
        .memReqValid  (memReqValid),
        .deliver      (deliver),
        .hitTouch     (hitTouch),
        .fillEn       (fillEn)
    );

    fetchPairSelect pairSelect (
        .deliver    (deliver),
        .lookupPc   (lookupPc),
        .lookupLine (lookupLine),
        .inst0Valid (inst0Valid),
        .inst0      (inst0),
        .inst0Pc    (inst0Pc),
        .inst1Valid (inst1Valid),
        .inst1      (inst1),
        .inst1Pc    (inst1Pc)
    );

endmodule

`default_nettype wire

//--- hdl/fetchPairSelect.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_macros.svh"

module fetchPairSelect
    import icachePkg::*;
(
    input  logic      deliver,
    input  cacheAddrT lookupPc,
    input  cacheLineT lookupLine,
    output logic      inst0Valid,
    output instWordT  inst0,
    output cacheAddrT inst0Pc,
    output logic      inst1Valid,
    output instWordT  inst1,
    output cacheAddrT inst1Pc
);

    localparam int WordsPerLine = `ICACHE_LINE_BITS / `ICACHE_INST_BITS;

    instWordT lineWords [WordsPerLine];

    always_comb begin
        for (int i = 0; i < WordsPerLine; i++) begin
            lineWords[i] = lookupLine[i*`ICACHE_INST_BITS +: `ICACHE_INST_BITS];
        end
    end

    // PC bit 3 picks the lower or upper pair of the line
    assign inst0 = lineWords[{lookupPc[3], 1'b0}];
    assign inst1 = lineWords[{lookupPc[3], 1'b1}];

    assign inst0Pc = {lookupPc[`ICACHE_ADDR_BITS-1:3], 3'b000};
    assign inst1Pc = inst0Pc + cacheAddrT'(4);

    // fetch into the odd slot only yields the second word
    assign inst0Valid = deliver && !lookupPc[2];
    assign inst1Valid = deliver;

endmodule

`default_nettype wire

//--- hdl/refillControl.sv
`timescale 1ns/100ps
`default_nettype none

module refillControl
    import icachePkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic lookupValid,
    input  logic hit,
    input  logic memRespValid,
    output logic stallReq,
    output logic memReqValid,
    output logic deliver,
    output logic hitTouch,
    output logic fillEn
);

    refillStateT state;
    refillStateT nextState;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lookupState;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState   = state;
        stallReq    = 1'b0;
        memReqValid = 1'b0;
        deliver     = 1'b0;
        hitTouch    = 1'b0;
        fillEn      = 1'b0;
        case (state)
            lookupState: begin
                if (lookupValid && hit) begin
                    hitTouch = 1'b1;
                    deliver  = !flush;
                end else if (lookupValid && !flush) begin
                    // single line request, then wait for memory
                    memReqValid = 1'b1;
                    stallReq    = 1'b1;
                    nextState   = missWaitState;
                end
            end
            missWaitState: begin
                stallReq = !memRespValid;
                if (memRespValid) begin
                    fillEn    = 1'b1;
                    deliver   = !flush;
                    nextState = lookupState;
                end else if (flush) begin
                    nextState = flushDrainState;
                end
            end
            flushDrainState: begin
                // the response is dropped and nothing is installed
                stallReq = !memRespValid;
                if (memRespValid) begin
                    nextState = lookupState;
                end
            end
            default: begin
                nextState = lookupState;
            end
        endcase
    end

    reqInLookup: assert property (@(posedge clk) disable iff (rst)
        memReqValid |-> state == lookupState)
        else $error("refillControl: request outside lookupState");

    reqSinglePulse: assert property (@(posedge clk) disable iff (rst)
        memReqValid |=> !memReqValid)
        else $error("refillControl: request held for two cycles");

endmodule

`default_nettype wire

//--- hdl/plruTracker.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_macros.svh"

module plruTracker
    import icachePkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  setIndexT lookupSet,
    input  logic     hitTouch,
    input  wayMaskT  hitWay,
    input  logic     fillEn,
    output wayMaskT  victimWay
);

    plruBitsT plruBits [`ICACHE_SETS];
    plruBitsT setBits;

    // mark a way as most recently used
    function automatic plruBitsT touchWay(plruBitsT bits, wayMaskT way);
        plruBitsT nextBits;
        nextBits = bits;
        if (way[0] || way[1]) begin
            nextBits[0] = 1'b0;
            nextBits[1] = way[1];
        end else begin
            nextBits[0] = 1'b1;
            nextBits[2] = way[3];
        end
        return nextBits;
    endfunction

    assign setBits = plruBits[lookupSet];

    // evict from the pair that was not used last
    always_comb begin
        if (setBits[0]) begin
            victimWay = setBits[1] ? wayMaskT'(4'b0001) : wayMaskT'(4'b0010);
        end else begin
            victimWay = setBits[2] ? wayMaskT'(4'b0100) : wayMaskT'(4'b1000);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                plruBits[s] <= '0;
            end
        end else if (fillEn) begin
            plruBits[lookupSet] <= touchWay(setBits, victimWay);
        end else if (hitTouch) begin
            plruBits[lookupSet] <= touchWay(setBits, hitWay);
        end
    end

    victimOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(victimWay))
        else $error("plruTracker: victim %b is not one-hot", victimWay);

endmodule

`default_nettype wire

//--- hdl/tagLookup.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_macros.svh"

module tagLookup
    import icachePkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  cacheAddrT fetchPc,
    input  logic      fetchValid,
    input  logic      flush,
    input  logic      stallReq,
    input  logic      fillEn,
    input  wayMaskT   victimWay,
    input  cacheLineT memRespLine,
    output logic      lookupValid,
    output logic      hit,
    output wayMaskT   hitWay,
    output setIndexT  lookupSet,
    output cacheAddrT lookupPc,
    output cacheAddrT memReqAddr,
    output cacheLineT lookupLine
);

    cacheAddrT heldPc;
    cacheTagT  heldTag;
    setIndexT  readSet;
    cacheTagT  wayTag  [`ICACHE_WAYS];
    cacheLineT wayLine [`ICACHE_WAYS];
    logic [`ICACHE_SETS-1:0] validBits [`ICACHE_WAYS];

    // held fetch address stays frozen while stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            lookupValid <= 1'b0;
        end else if (!stallReq) begin
            lookupValid <= fetchValid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallReq) begin
            heldPc <= fetchPc;
        end
    end

    assign heldTag   = heldPc[`ICACHE_ADDR_BITS-1 -: `ICACHE_TAG_BITS];
    assign lookupSet = heldPc[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    assign lookupPc  = heldPc;
    assign memReqAddr = {heldPc[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS],
                         {`ICACHE_OFFSET_BITS{1'b0}}};

    // keep re-reading the held set during a miss
    assign readSet = stallReq ? lookupSet : fetchPc[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                validBits[w] <= '0;
            end
        end else if (fillEn) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (victimWay[w]) begin
                    validBits[w][lookupSet] <= 1'b1;
                end
            end
        end
    end

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : gWay
        wayRam #(.payloadT(cacheTagT)) tagRam (
            .clk       (clk),
            .writeEn   (fillEn && victimWay[w]),
            .addr      (readSet),
            .writeData (heldTag),
            .readData  (wayTag[w])
        );

        wayRam #(.payloadT(cacheLineT)) dataRam (
            .clk       (clk),
            .writeEn   (fillEn && victimWay[w]),
            .addr      (readSet),
            .writeData (memRespLine),
            .readData  (wayLine[w])
        );

        assign hitWay[w] = lookupValid && validBits[w][lookupSet] && wayTag[w] == heldTag;
    end

    assign hit = |hitWay;

    // on a miss the response line goes straight to the pair select
    always_comb begin
        lookupLine = memRespLine;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (hitWay[w]) begin
                lookupLine = wayLine[w];
            end
        end
    end

    // a line is only ever installed in one way of its set
    hitOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(hitWay))
        else $error("tagLookup: several ways hit on %h", heldPc);

endmodule

`default_nettype wire

//--- hdl/wayRam.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_macros.svh"

module wayRam
    import icachePkg::*;
#(
    parameter type payloadT = cacheLineT
) (
    input  logic     clk,
    input  logic     writeEn,
    input  setIndexT addr,
    input  payloadT  writeData,
    output payloadT  readData
);

    payloadT  mem [`ICACHE_SETS];
    setIndexT shownAddr;

    // a write lands on the entry currently shown on readData
    always_ff @(posedge clk) begin
        shownAddr <= addr;
        if (writeEn) begin
            mem[shownAddr] <= writeData;
        end
        // write-first when the next read hits the same entry
        if (writeEn && addr == shownAddr) begin
            readData <= writeData;
        end else begin
            readData <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- hdl/icachePkg.sv
`default_nettype none

`include "icache_macros.svh"

package icachePkg;

    typedef logic [`ICACHE_ADDR_BITS-1:0] cacheAddrT;

    typedef logic [`ICACHE_TAG_BITS-1:0] cacheTagT;

    typedef logic [`ICACHE_INDEX_BITS-1:0] setIndexT;

    // word 0 sits in the lowest 32 bits
    typedef logic [`ICACHE_LINE_BITS-1:0] cacheLineT;

    typedef logic [`ICACHE_INST_BITS-1:0] instWordT;

    // one bit per way and one-hot when in use
    typedef logic [`ICACHE_WAYS-1:0] wayMaskT;

    // tree pLRU with bit 0 as the root
    typedef logic [2:0] plruBitsT;

    typedef enum logic [1:0] {
        lookupState,
        missWaitState,
        flushDrainState
    } refillStateT;

endpackage

`default_nettype wire

//--- hdl/icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// 4-way, 64 sets of 16-byte lines
`define ICACHE_WAYS        4
`define ICACHE_SETS        64
`define ICACHE_INDEX_BITS  6
`define ICACHE_OFFSET_BITS 4

// tag is address bits 31 to 10
`define ICACHE_TAG_BITS    22

`define ICACHE_LINE_BITS   128
`define ICACHE_INST_BITS   32
`define ICACHE_ADDR_BITS   32

`endif
